//--- gat_settings.svh
`ifndef GAT_SETTINGS_SVH
`define GAT_SETTINGS_SVH

// Row-sum buffer geometry
`define GAT_FIFO_DEPTH 4
`define GAT_FIFO_AW 2

// Rows folded into one node result
`define GAT_ROWS_PER_NODE 3

// Zero-based popped row captured by the debug monitor
`define GAT_PROBE_ROW 5

`endif

//--- gat_pkg.sv
package gat_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Nonzero value and weight share one format
  typedef logic [11:0] nz_val_t;

  // 24-bit products accumulate with modulo 2^32 wrap
  typedef logic [31:0] row_sum_t;

  // Group of row sums, same wrap rule
  typedef logic [31:0] node_sum_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Node aggregator FSM
  typedef enum logic {
    AGG_COLLECT,  // Popping rows into the node sum
    AGG_EMIT      // Holding a finished node result
  } agg_state_e;

endpackage

//--- spmm_row_engine.sv
`timescale 1ns/10ps
`include "gat_settings.svh"

module spmm_row_engine (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              nz_vld_i,
  input  logic              nz_last_i,
  input  gat_pkg::nz_val_t  nz_val_i,
  input  gat_pkg::nz_val_t  nz_wgt_i,
  output logic              nz_rdy_o,
  output logic              row_vld_o,
  output gat_pkg::row_sum_t row_sum_o,
  input  logic              row_rdy_i
);

  logic [23:0]       product;
  logic              nz_take;
  logic              row_push;
  gat_pkg::row_sum_t acc_q;
  gat_pkg::row_sum_t hold_q;
  logic              row_vld_q;

  assign product  = nz_val_i * nz_wgt_i;       // Full 24-bit product
  assign nz_take  = nz_vld_i & nz_rdy_o;
  assign row_push = row_vld_q & row_rdy_i;

  assign nz_rdy_o  = ~row_vld_q;               // Stall input while a row waits
  assign row_vld_o = row_vld_q;
  assign row_sum_o = hold_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Running row accumulator
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q     <= '0;
      row_vld_q <= 1'b0;
    end else begin
      if (nz_take) begin
        if (nz_last_i) begin
          acc_q     <= '0;                     // Next row starts clean
          row_vld_q <= 1'b1;
        end else begin
          acc_q <= acc_q + product;
        end
      end else if (row_push) begin
        row_vld_q <= 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Finished row, offered to the FIFO until pushed
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (nz_take && nz_last_i) begin
      hold_q <= acc_q + product;               // Includes the last product
    end
  end

endmodule

//--- row_fifo.sv
`timescale 1ns/10ps
`include "gat_settings.svh"

module row_fifo (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_i,
  input  gat_pkg::row_sum_t push_data_i,
  input  logic              pop_i,
  output gat_pkg::row_sum_t head_o,
  output logic              full_o,
  output logic              empty_o
);

  localparam logic [`GAT_FIFO_AW-1:0] LAST_IDX = `GAT_FIFO_AW'(`GAT_FIFO_DEPTH - 1);

  gat_pkg::row_sum_t       mem [`GAT_FIFO_DEPTH];
  logic [`GAT_FIFO_AW-1:0] wr_ptr;
  logic [`GAT_FIFO_AW-1:0] rd_ptr;
  logic [`GAT_FIFO_AW:0]   count;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (count == (`GAT_FIFO_AW+1)'(`GAT_FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i & ~full_o;           // Push on full is dropped
  assign do_pop  = pop_i & ~empty_o;
  assign head_o  = mem[rd_ptr];                // Fall-through head

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;               // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

endmodule

//--- node_aggregator.sv
`timescale 1ns/10ps
`include "gat_settings.svh"

module node_aggregator (
  input  logic               clk,
  input  logic               rst_n,
  input  gat_pkg::row_sum_t  head_i,
  input  logic               empty_i,
  output logic               pop_o,
  output logic               node_vld_o,
  output gat_pkg::node_sum_t node_sum_o,
  input  logic               node_rdy_i
);

  localparam int CW = $clog2(`GAT_ROWS_PER_NODE + 1);
  localparam logic [CW-1:0] LAST_ROW = CW'(`GAT_ROWS_PER_NODE - 1);

  gat_pkg::agg_state_e state_q;
  gat_pkg::agg_state_e state_d;
  logic [CW-1:0]       row_cnt_q;
  gat_pkg::node_sum_t  sum_q;
  logic                last_pop;

  assign pop_o      = (state_q == gat_pkg::AGG_COLLECT) & ~empty_i;
  assign last_pop   = pop_o & (row_cnt_q == LAST_ROW);
  assign node_vld_o = (state_q == gat_pkg::AGG_EMIT);
  assign node_sum_o = sum_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d = state_q;
    case (state_q)
      gat_pkg::AGG_COLLECT: if (last_pop)   state_d = gat_pkg::AGG_EMIT;
      gat_pkg::AGG_EMIT:    if (node_rdy_i) state_d = gat_pkg::AGG_COLLECT;
      default:              state_d = gat_pkg::AGG_COLLECT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= gat_pkg::AGG_COLLECT;
      row_cnt_q <= '0;
      sum_q     <= '0;
    end else begin
      state_q <= state_d;
      if (pop_o) begin
        sum_q     <= sum_q + head_i;           // Wraps modulo 2^32
        row_cnt_q <= last_pop ? '0 : row_cnt_q + 1'b1;
      end else if (node_vld_o && node_rdy_i) begin
        sum_q <= '0;                           // Result taken
      end
    end
  end

endmodule

//--- debug_monitor.sv
`timescale 1ns/10ps
`include "gat_settings.svh"

module debug_monitor (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              nz_vld_i,
  input  logic              nz_rdy_i,
  input  logic              row_vld_i,
  input  logic              row_rdy_i,
  input  logic              pop_i,
  input  logic              node_vld_i,
  input  logic              node_rdy_i,
  input  gat_pkg::row_sum_t head_i,
  output logic [31:0]       dbg_flags_o,
  output logic [31:0]       dbg_rows_o,
  output logic [31:0]       dbg_probe_o
);

  logic [6:0]  seen;
  logic [6:0]  flags_q;
  logic [31:0] rows_q;
  logic [31:0] probe_q;

  // Bit order follows the pipeline, input side first
  assign seen = {node_rdy_i, node_vld_i, pop_i, row_rdy_i,
                 row_vld_i, nz_rdy_i, nz_vld_i};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sticky flags, popped-row count, probed row sum
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      rows_q  <= '0;
      probe_q <= '0;
    end else begin
      flags_q <= flags_q | seen;               // Set once, never cleared
      if (pop_i) begin
        rows_q <= rows_q + 1'b1;
        if (rows_q == 32'(`GAT_PROBE_ROW)) begin
          probe_q <= head_i;                   // Head being popped now
        end
      end
    end
  end

  assign dbg_flags_o = {25'b0, flags_q};
  assign dbg_rows_o  = rows_q;
  assign dbg_probe_o = probe_q;

endmodule

//--- gat_slice_top.sv
`timescale 1ns/10ps

module gat_slice_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               nz_vld_i,
  input  gat_pkg::nz_val_t   nz_val_i,
  input  gat_pkg::nz_val_t   nz_wgt_i,
  input  logic               nz_last_i,
  output logic               nz_rdy_o,
  output logic               node_vld_o,
  output gat_pkg::node_sum_t node_sum_o,
  input  logic               node_rdy_i,
  output logic [31:0]        dbg_flags_o,
  output logic [31:0]        dbg_rows_o,
  output logic [31:0]        dbg_probe_o
);

  logic              row_vld;
  logic              row_rdy;
  gat_pkg::row_sum_t row_sum;
  gat_pkg::row_sum_t head;
  logic              fifo_full;
  logic              fifo_empty;
  logic              pop;

  assign row_rdy = ~fifo_full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Producer, buffer, consumer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  spmm_row_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .nz_vld_i  (nz_vld_i),
    .nz_last_i (nz_last_i),
    .nz_val_i  (nz_val_i),
    .nz_wgt_i  (nz_wgt_i),
    .nz_rdy_o  (nz_rdy_o),
    .row_vld_o (row_vld),
    .row_sum_o (row_sum),
    .row_rdy_i (row_rdy)
  );

  row_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (row_vld),                    // Dropped by the FIFO when full
    .push_data_i (row_sum),
    .pop_i       (pop),
    .head_o      (head),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty)
  );

  node_aggregator u_aggr (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_i     (head),
    .empty_i    (fifo_empty),
    .pop_o      (pop),
    .node_vld_o (node_vld_o),
    .node_sum_o (node_sum_o),
    .node_rdy_i (node_rdy_i)
  );

  debug_monitor u_dbg (
    .clk         (clk),
    .rst_n       (rst_n),
    .nz_vld_i    (nz_vld_i),
    .nz_rdy_i    (nz_rdy_o),
    .row_vld_i   (row_vld),
    .row_rdy_i   (row_rdy),
    .pop_i       (pop),
    .node_vld_i  (node_vld_o),
    .node_rdy_i  (node_rdy_i),
    .head_i      (head),
    .dbg_flags_o (dbg_flags_o),
    .dbg_rows_o  (dbg_rows_o),
    .dbg_probe_o (dbg_probe_o)
  );

endmodule

//--- gat_checker.sv
`timescale 1ns/10ps
`include "gat_settings.svh"

module gat_checker #(
  parameter int ROWS = 48
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               nz_vld_i,
  input  logic               nz_rdy_i,
  input  logic               nz_last_i,
  input  gat_pkg::nz_val_t   nz_val_i,
  input  gat_pkg::nz_val_t   nz_wgt_i,
  input  logic               node_vld_i,
  input  logic               node_rdy_i,
  input  gat_pkg::node_sum_t node_sum_i,
  input  logic [31:0]        dbg_flags_i,
  input  logic [31:0]        dbg_rows_i,
  input  logic [31:0]        dbg_probe_i,
  input  logic               end_i,
  output int                 nodes_o,
  output int                 errors_o,
  output int                 failed_o,
  output logic               done_o
);

  localparam int NODES = ROWS / `GAT_ROWS_PER_NODE;

  logic [31:0] row_q [$];                      // Every finished row, in order
  logic [31:0] node_q [$];                     // Node results not yet taken
  logic [31:0] acc;
  logic [31:0] node_acc;
  int          rows_in_node;
  logic [6:0]  seen;
  logic        reset_done;
  logic        prev_vld;
  logic        prev_rdy;
  logic [31:0] prev_sum;
  int          err [5];

  initial begin
    acc          = '0;
    node_acc     = '0;
    rows_in_node = 0;
    seen         = '0;
    reset_done   = 1'b0;
    prev_vld     = 1'b0;
    prev_rdy     = 1'b0;
    prev_sum     = '0;
    nodes_o      = 0;
    errors_o     = 0;
    failed_o     = 0;
    done_o       = 1'b0;
    foreach (err[t]) err[t] = 0;
  end

  task automatic report(input int t, input string name);
    if (err[t] == 0) begin
      $display("Test %0d %s: PASS", t + 1, name);
    end else begin
      $display("Test %0d %s: FAIL (%0d errors)", t + 1, name, err[t]);
      failed_o++;
    end
    errors_o += err[t];
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-cycle model and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin : watch
    logic [31:0] prod;
    logic [31:0] exp_sum;
    if (rst_n) begin
      if (!reset_done) begin
        if (nz_rdy_i !== 1'b1 || node_vld_i !== 1'b0 || dbg_flags_i !== '0 ||
            dbg_rows_i !== '0 || dbg_probe_i !== '0) begin
          $display("Error at %0t: after reset nz_rdy=%b node_vld=%b flags=0x%h",
                   $time, nz_rdy_i, node_vld_i, dbg_flags_i);
          $display("Error at %0t: after reset rows=%0d probe=0x%h",
                   $time, dbg_rows_i, dbg_probe_i);
          err[0]++;
        end
        reset_done = 1'b1;
        report(0, "reset state");
      end
      seen = seen | {node_rdy_i, node_vld_i, 3'b000, nz_rdy_i, nz_vld_i};
      if (nz_vld_i && nz_rdy_i) begin
        prod = 32'(nz_val_i) * 32'(nz_wgt_i);  // 24-bit product
        acc  = acc + prod;
        if (nz_last_i) begin
          row_q.push_back(acc);
          node_acc = node_acc + acc;
          acc      = '0;
          rows_in_node++;
          if (rows_in_node == `GAT_ROWS_PER_NODE) begin
            node_q.push_back(node_acc);
            node_acc     = '0;
            rows_in_node = 0;
          end
        end
      end
      if (prev_vld && !prev_rdy && (node_vld_i !== 1'b1 || node_sum_i !== prev_sum)) begin
        $display("Error at %0t: node output moved while stalled, vld=%b sum=0x%08h held 0x%08h",
                 $time, node_vld_i, node_sum_i, prev_sum);
        err[2]++;
      end
      if (node_vld_i && node_rdy_i) begin
        nodes_o++;
        if (node_q.size() == 0) begin
          $display("Error at %0t: node %0d was taken before its rows arrived",
                   $time, nodes_o - 1);
          err[2]++;
        end else begin
          exp_sum = node_q.pop_front();
          if (node_sum_i !== exp_sum) begin
            $display("Error at %0t: node %0d sum 0x%08h, expected 0x%08h",
                     $time, nodes_o - 1, node_sum_i, exp_sum);
            err[1]++;
          end
        end
      end
      prev_vld = node_vld_i;
      prev_rdy = node_rdy_i;
      prev_sum = node_sum_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // End-of-run checks on counts and debug words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge end_i) begin : finale
    logic [6:0] exp_flags;
    // Engine, FIFO and pop levels must have toggled if rows flowed
    exp_flags = seen | ((row_q.size() > 0) ? 7'b0011100 : 7'b0000000);
    if (nodes_o != NODES) begin
      $display("Error at %0t: %0d nodes taken, expected %0d", $time, nodes_o, NODES);
      err[1]++;
    end
    report(1, "node sums");
    if (node_q.size() != 0) begin
      $display("Rows were lost or duplicated: %0d modeled nodes were never taken",
               node_q.size());
      err[2]++;
    end
    report(2, "back-pressure");
    if (dbg_flags_i !== {25'b0, exp_flags}) begin
      $display("Error at %0t: dbg_flags 0x%08h, expected 0x%08h",
               $time, dbg_flags_i, exp_flags);
      err[3]++;
    end
    report(3, "stage flags");
    if (dbg_rows_i !== 32'(ROWS)) begin
      $display("Error at %0t: dbg_rows %0d, expected %0d", $time, dbg_rows_i, ROWS);
      err[4]++;
    end
    if (dbg_probe_i !== row_q[`GAT_PROBE_ROW]) begin
      $display("Error at %0t: dbg_probe 0x%08h, expected 0x%08h",
               $time, dbg_probe_i, row_q[`GAT_PROBE_ROW]);
      err[4]++;
    end
    report(4, "row count and probe");
    done_o = 1'b1;
  end

endmodule

//--- tb_gat_slice.sv
`timescale 1ns/10ps
`include "gat_settings.svh"

module tb_gat_slice;

  localparam int ROWS     = 48;
  localparam int NODES    = ROWS / `GAT_ROWS_PER_NODE;
  localparam int LIMIT_NS = ROWS * 5 * 4 * 8 + 4000;  // Longest row traffic plus margin

  logic               clk;
  logic               rst_n;
  logic               nz_vld_i;
  gat_pkg::nz_val_t   nz_val_i;
  gat_pkg::nz_val_t   nz_wgt_i;
  logic               nz_last_i;
  logic               nz_rdy_o;
  logic               node_vld_o;
  gat_pkg::node_sum_t node_sum_o;
  logic               node_rdy_i;
  logic [31:0]        dbg_flags_o;
  logic [31:0]        dbg_rows_o;
  logic [31:0]        dbg_probe_o;
  logic               end_run;
  logic               took;
  logic               report_done;
  logic [31:0]        lcg_state;
  int                 rdy_run;
  int                 nodes;
  int                 errors;
  int                 failed;

  always #4 clk = ~clk;

  always @(posedge clk) took <= nz_vld_i & nz_rdy_o;  // Nonzero accepted at this edge

  gat_slice_top DUT (
    .clk (clk), .rst_n (rst_n),
    .nz_vld_i (nz_vld_i), .nz_val_i (nz_val_i), .nz_wgt_i (nz_wgt_i),
    .nz_last_i (nz_last_i), .nz_rdy_o (nz_rdy_o),
    .node_vld_o (node_vld_o), .node_sum_o (node_sum_o), .node_rdy_i (node_rdy_i),
    .dbg_flags_o (dbg_flags_o), .dbg_rows_o (dbg_rows_o), .dbg_probe_o (dbg_probe_o)
  );

  gat_checker #(.ROWS (ROWS)) u_checker (
    .clk (clk), .rst_n (rst_n),
    .nz_vld_i (nz_vld_i), .nz_rdy_i (nz_rdy_o), .nz_last_i (nz_last_i),
    .nz_val_i (nz_val_i), .nz_wgt_i (nz_wgt_i),
    .node_vld_i (node_vld_o), .node_rdy_i (node_rdy_i), .node_sum_i (node_sum_o),
    .dbg_flags_i (dbg_flags_o), .dbg_rows_i (dbg_rows_o), .dbg_probe_i (dbg_probe_o),
    .end_i (end_run), .nodes_o (nodes), .errors_o (errors), .failed_o (failed),
    .done_o (report_done)
  );

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];                   // Upper bits are the better ones
  endfunction

  // Advance to the next falling edge and update node_rdy_i in random runs
  task automatic next_fall();
    logic [15:0] r;
    @(negedge clk);
    if (rdy_run == 0) begin
      r          = lcg_next();
      node_rdy_i = r[15];
      rdy_run    = 1 + int'(r % 16'd24);
    end
    rdy_run--;
  endtask

  initial begin
    int          n;
    logic [15:0] r;
    clk        = 1'b0;
    rst_n      = 1'b0;
    nz_vld_i   = 1'b0;
    nz_val_i   = '0;
    nz_wgt_i   = '0;
    nz_last_i  = 1'b0;
    node_rdy_i = 1'b0;
    end_run    = 1'b0;
    lcg_state  = 32'd44204;
    rdy_run    = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int row = 0; row < ROWS; row++) begin
      n = 1 + int'(lcg_next() % 16'd5);
      for (int k = 0; k < n; k++) begin
        while (lcg_next() % 16'd4 == 0) begin
          nz_vld_i = 1'b0;
          next_fall();
        end
        r         = lcg_next();
        nz_val_i  = r[11:0];
        r         = lcg_next();
        nz_wgt_i  = r[11:0];
        nz_vld_i  = 1'b1;
        nz_last_i = (k == n - 1);
        next_fall();
        while (!took) next_fall();             // Held until the engine takes it
      end
    end
    nz_vld_i  = 1'b0;
    nz_last_i = 1'b0;
    while (nodes < NODES) next_fall();
    repeat (8) next_fall();                    // Room for a stray extra node
    end_run = 1'b1;
    wait (report_done);
    $display("Summary: 5 tests, %0d failed, %0d errors, %0d nodes taken", failed, errors, nodes);
    if (failed == 0 && errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(LIMIT_NS);
    $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
gat_pkg.sv
spmm_row_engine.sv
row_fifo.sv
node_aggregator.sv
debug_monitor.sv
gat_slice_top.sv
gat_checker.sv
tb_gat_slice.sv

//--- Bender.yml
package:
  name: gat_slice

sources:
  - include_dirs:
      - .
    files:
      - gat_pkg.sv
      - spmm_row_engine.sv
      - row_fifo.sv
      - node_aggregator.sv
      - debug_monitor.sv
      - gat_slice_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - gat_checker.sv
      - tb_gat_slice.sv
